//--- list.f
verilog/dcache_pkg.sv
verilog/dcache_data.sv
verilog/dcache_tags.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
sim/wb_mem_model.sv
sim/tb_dcache.sv

//--- Makefile
TOP = tb_dcache

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -sv -f list.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only --timing --assert -sv -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_dcache.sv
// data cache testbench: clock, reset, LFSR stimulus, reference model, tests and reporting
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
	import dcache_pkg::*;

	localparam int SET_BITS = 3;
	localparam int MEM_BITS = 8;
	localparam logic [31:0] SEED = 32'h54df_7db7;
	localparam int RESET_CYCLES = 8;
	localparam int N_RANDOM = 300;
	localparam int N_DIRECTED = 40;
	localparam int BEAT_MAX = 6; // request, up to 3 waits, ack
	localparam int MISS_COST = 4 * BEAT_MAX + 4;
	localparam int FLUSH_COST = 2 * (2 ** SET_BITS) * (1 + 2 * BEAT_MAX);
	localparam int LIMIT = RESET_CYCLES + (N_RANDOM + N_DIRECTED) * MISS_COST
		+ FLUSH_COST + 20;

	logic CLK = 1'b0;
	logic nRST;
	cpu_req_t req;
	logic halt;
	logic hit;
	word_t rdata;
	logic flushed;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic [1:0] ack_delay = 2'd0;
	logic [31:0] lfsr_ack = SEED;
	logic [31:0] lfsr_op;

	word_t ref_mem [2 ** MEM_BITS];
	word_t rsv_addr;
	logic rsv_valid;
	word_t rd_beats [$];
	word_t wr_beats [$];
	int n_beats;
	int cycles;
	int checks;
	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;

	always #5 CLK = ~CLK;

	dcache_top #(
		.SET_BITS(SET_BITS)
	) i_dut (
		.CLK(CLK),
		.nRST(nRST),
		.req_i(req),
		.halt_i(halt),
		.hit_o(hit),
		.rdata_o(rdata),
		.flushed_o(flushed),
		.wb_o(wb_req),
		.wb_i(wb_rsp)
	);

	wb_mem_model #(
		.ADDR_BITS(MEM_BITS)
	) i_mem (
		.CLK(CLK),
		.nRST(nRST),
		.wb_i(wb_req),
		.wb_o(wb_rsp),
		.delay_i(ack_delay)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic word_t take_bits(input int n);
		word_t v;
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr_op = lfsr_next(lfsr_op);
			v = {v[30:0], lfsr_op[0]};
		end
		return v;
	endfunction

	// code is {tag select, set, word}; select 3 folds onto the first tag
	function automatic word_t addr_of(input logic [5:0] code);
		logic [25:0] tag;
		case (code[5:4])
			2'd1: tag = 26'd5;
			2'd2: tag = 26'd12;
			default: tag = 26'd1;
		endcase
		return {tag, code[3:1], code[0], 2'b00};
	endfunction

	function automatic word_t init_word(input word_t a);
		return (a * 32'h9e37_79b9) ^ 32'h0f0f_1234;
	endfunction

	always @(posedge CLK)
	begin
		#1;
		lfsr_ack = lfsr_next(lfsr_ack);
		ack_delay[0] = lfsr_ack[0];
		lfsr_ack = lfsr_next(lfsr_ack);
		ack_delay[1] = lfsr_ack[0];
	end

	always @(negedge CLK)
	begin
		if (nRST && wb_req.cyc && wb_req.stb && wb_rsp.ack)
		begin
			n_beats++;
			if (wb_req.we)
				wr_beats.push_back(wb_req.adr);
			else
				rd_beats.push_back(wb_req.adr);
		end
	end

	always @(posedge CLK)
	begin
		cycles++;
		if (cycles > LIMIT)
		begin
			$display("timeout: run still busy after %0d cycles", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic check_value(input string what, input word_t got, input word_t exp);
		checks++;
		assert (got == exp)
		else
		begin
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
			test_errors++;
		end
	endtask

	// starts and ends just after a rising edge
	task automatic access(input logic ren, input logic wen, input logic atomic,
		input word_t addr, input word_t wdata, output word_t got);
		req.ren = ren;
		req.wen = wen;
		req.atomic = atomic;
		req.addr = addr;
		req.wdata = wdata;
		@(negedge CLK);
		while (!hit)
			@(negedge CLK);
		got = rdata;
		@(posedge CLK);
		#1;
		req = '0;
	endtask

	task automatic run_op(input logic ren, input logic atomic, input word_t addr,
		input word_t wdata);
		word_t got;
		word_t exp;
		logic [MEM_BITS-1:0] idx;
		idx = addr[MEM_BITS+1:2];
		exp = '0;
		if (ren)
		begin
			exp = ref_mem[idx];
			if (atomic)
			begin
				rsv_addr = addr;
				rsv_valid = 1'b1;
			end
		end
		else if (!atomic || (rsv_valid && rsv_addr == addr))
		begin
			ref_mem[idx] = wdata;
			if (atomic)
				exp = 32'd1; // SC success answers 1
			if (rsv_addr == addr)
				rsv_valid = 1'b0;
		end
		access(ren, !ren, atomic, addr, wdata, got);
		if (ren || atomic)
			check_value($sformatf("%s %h", ren ? "load" : "sc", addr), got, exp);
	endtask

	task automatic end_test(input int num, input string name);
		tests_run++;
		errors += test_errors;
		if (test_errors == 0)
			$display("test %0d %s: ok", num, name);
		else
		begin
			$display("test %0d %s: FAILED with %0d errors", num, name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	initial
	begin
		word_t a;
		word_t b;
		word_t c;
		logic [2:0] op;
		int rd_mark;
		int beat_mark;

		nRST = 1'b0;
		req = '0;
		halt = 1'b0;
		lfsr_op = SEED;
		rsv_addr = '0;
		rsv_valid = 1'b0;
		for (int i = 0; i < 2 ** MEM_BITS; i++)
			ref_mem[i] = init_word(word_t'(i) << 2);
		repeat (RESET_CYCLES) @(posedge CLK);
		#1;
		nRST = 1'b1;

		for (int s = 0; s < 4; s++)
		begin
			a = addr_of({2'd0, 3'(s), 1'(s)});
			rd_mark = rd_beats.size();
			beat_mark = n_beats;
			run_op(1'b1, 1'b0, a, '0);
			check_value("cold read beats", word_t'(rd_beats.size() - rd_mark), 2);
			check_value("cold total beats", word_t'(n_beats - beat_mark), 2);
			if (rd_beats.size() - rd_mark == 2)
			begin
				check_value("first fill address", rd_beats[rd_mark], {a[31:3], 3'b000});
				check_value("second fill address", rd_beats[rd_mark + 1], {a[31:3], 3'b100});
			end
		end
		end_test(1, "cold read");

		for (int i = 0; i < N_RANDOM; i++)
		begin
			op = 3'(take_bits(3));
			a = addr_of(6'(take_bits(6)));
			b = take_bits(32);
			if (op == 3'd6)
				run_op(1'b1, 1'b1, a, b); // LL
			else if (op == 3'd7)
				run_op(1'b0, 1'b1, a, b); // SC
			else
				run_op(op < 3'd3, 1'b0, a, b);
		end
		end_test(2, "random loads and stores");

		a = addr_of({2'd0, 3'd6, 1'b0});
		b = addr_of({2'd1, 3'd6, 1'b0});
		c = addr_of({2'd2, 3'd6, 1'b0});
		run_op(1'b1, 1'b0, a, '0);
		run_op(1'b0, 1'b0, b, 32'hb0b0_0b0b); // B dirty, so C evicts it by writeback
		run_op(1'b1, 1'b0, a, '0);
		rd_mark = rd_beats.size();
		beat_mark = wr_beats.size();
		run_op(1'b1, 1'b0, c, '0);
		check_value("fill beats of C", word_t'(rd_beats.size() - rd_mark), 2);
		if (rd_beats.size() - rd_mark == 2)
			check_value("fill block of C", rd_beats[rd_mark], {c[31:3], 3'b000});
		check_value("writeback beats on C miss", word_t'(wr_beats.size() - beat_mark), 2);
		for (int k = beat_mark; k < wr_beats.size(); k++)
			check_value("writeback block on C miss", {wr_beats[k][31:3], 3'b000},
				{b[31:3], 3'b000});
		beat_mark = n_beats;
		run_op(1'b1, 1'b0, a, '0);
		check_value("beats on reload of A", word_t'(n_beats - beat_mark), 0);
		end_test(3, "LRU replacement");

		a = addr_of({2'd1, 3'd2, 1'b1});
		b = addr_of({2'd2, 3'd4, 1'b0});
		run_op(1'b1, 1'b1, a, '0);
		run_op(1'b0, 1'b1, a, 32'h1111_0001); // linked, succeeds
		run_op(1'b1, 1'b0, a, '0);
		run_op(1'b0, 1'b1, a, 32'h2222_0002); // no reservation left
		run_op(1'b1, 1'b0, a, '0);
		run_op(1'b1, 1'b1, a, '0);
		run_op(1'b0, 1'b1, b, 32'h3333_0003); // other address
		run_op(1'b1, 1'b0, b, '0);
		run_op(1'b1, 1'b1, a, '0);
		run_op(1'b0, 1'b0, a, 32'h4444_0004);
		run_op(1'b0, 1'b1, a, 32'h5555_0005); // store broke the link
		run_op(1'b1, 1'b0, a, '0);
		run_op(1'b1, 1'b1, a, '0);
		run_op(1'b0, 1'b0, b, 32'h6666_0006);
		run_op(1'b0, 1'b1, a, 32'h7777_0007); // link survives a store elsewhere
		run_op(1'b1, 1'b0, a, '0);
		end_test(4, "LL/SC");

		halt = 1'b1;
		@(negedge CLK);
		while (!flushed)
			@(negedge CLK);
		for (int i = 0; i < 2 ** MEM_BITS; i++)
			check_value($sformatf("memory word %0d after flush", i), i_mem.mem_q[i], ref_mem[i]);
		end_test(5, "halt and flush");

		$display("%0d tests run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/wb_mem_model.sv
// Wishbone classic slave memory with a per-beat ack delay taken from an input
`timescale 1ns/1ps
`default_nettype none

module wb_mem_model #(
	parameter int ADDR_BITS = 8
) (
	input  wire logic                 CLK,
	input  wire logic                 nRST,
	input  wire dcache_pkg::wb_req_t  wb_i,
	output dcache_pkg::wb_rsp_t       wb_o,
	input  wire logic [1:0]           delay_i
);
	import dcache_pkg::*;

	localparam int DEPTH = 2 ** ADDR_BITS;

	word_t mem_q [DEPTH];
	logic ack_q;
	logic busy_q;
	logic [1:0] wait_q;
	logic ack_now;
	logic [ADDR_BITS-1:0] widx;

	assign widx = wb_i.adr[ADDR_BITS+1:2];
	assign ack_now = wb_i.cyc && wb_i.stb && busy_q && !ack_q && (wait_q == 2'd0);
	assign wb_o.ack = ack_q;
	assign wb_o.dat = mem_q[widx];

	// pattern is a function of the byte address
	initial
	begin
		for (int i = 0; i < DEPTH; i++)
			mem_q[i] = ((32'(i) << 2) * 32'h9e37_79b9) ^ 32'h0f0f_1234;
	end

	always @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
		begin
			ack_q <= 1'b0;
			busy_q <= 1'b0;
			wait_q <= 2'd0;
		end
		else
		begin
			ack_q <= 1'b0;
			if (ack_q)
				busy_q <= 1'b0; // beat done, next one may start
			else if (wb_i.cyc && wb_i.stb)
			begin
				if (!busy_q)
				begin
					busy_q <= 1'b1;
					wait_q <= delay_i;
				end
				else if (wait_q != 2'd0)
					wait_q <= wait_q - 2'd1;
				else
					ack_q <= 1'b1;
			end
		end
	end

	always @(posedge CLK)
	begin
		if (ack_now && wb_i.we)
			mem_q[widx] <= wb_i.dat;
	end

endmodule

`default_nettype wire

//--- verilog/dcache_top.sv
// data cache top: controller, tag array and data array
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
	parameter int SET_BITS = 3
) (
	input  wire logic                  CLK,
	input  wire logic                  nRST,
	input  wire dcache_pkg::cpu_req_t  req_i,
	input  wire logic                  halt_i,
	output logic                       hit_o,
	output dcache_pkg::word_t          rdata_o,
	output logic                       flushed_o,
	output dcache_pkg::wb_req_t        wb_o,
	input  wire dcache_pkg::wb_rsp_t   wb_i
);
	import dcache_pkg::*;

	localparam int TAG_BITS = 32 - OFF_BITS - SET_BITS;

	logic [SET_BITS-1:0] set;
	logic way;
	logic word;
	logic data_we;
	logic fill;
	logic mark_dirty;
	logic clean;
	logic touch;
	word_t data_wdata;
	word_t rd_word;
	logic tag_hit;
	logic hit_way;
	logic victim_way;
	logic victim_dirty;
	logic [TAG_BITS-1:0] req_tag;
	logic [TAG_BITS-1:0] victim_tag;

	assign req_tag = req_i.addr[31 -: TAG_BITS];

	dcache_ctrl #(
		.SET_BITS(SET_BITS)
	) i_ctrl (
		.CLK(CLK),
		.nRST(nRST),
		.req_i(req_i),
		.halt_i(halt_i),
		.hit_o(hit_o),
		.rdata_o(rdata_o),
		.flushed_o(flushed_o),
		.wb_o(wb_o),
		.wb_i(wb_i),
		.tag_hit_i(tag_hit),
		.hit_way_i(hit_way),
		.victim_way_i(victim_way),
		.victim_dirty_i(victim_dirty),
		.victim_tag_i(victim_tag),
		.rd_word_i(rd_word),
		.set_o(set),
		.way_o(way),
		.word_o(word),
		.data_we_o(data_we),
		.data_o(data_wdata),
		.fill_o(fill),
		.mark_dirty_o(mark_dirty),
		.clean_o(clean),
		.touch_o(touch),
		.flush_set_o()
	);

	dcache_tags #(
		.SET_BITS(SET_BITS)
	) i_tags (
		.CLK(CLK),
		.nRST(nRST),
		.set_i(set),
		.tag_i(req_tag),
		.fill_i(fill),
		.way_i(way),
		.mark_dirty_i(mark_dirty),
		.clean_i(clean),
		.touch_i(touch),
		.hit_o(tag_hit),
		.hit_way_o(hit_way),
		.victim_way_o(victim_way),
		.victim_dirty_o(victim_dirty),
		.victim_tag_o(victim_tag)
	);

	dcache_data #(
		.SET_BITS(SET_BITS)
	) i_data (
		.CLK(CLK),
		.set_i(set),
		.way_i(way),
		.word_i(word),
		.we_i(data_we),
		.wdata_i(data_wdata),
		.rdata_o(rd_word)
	);

endmodule

`default_nettype wire

//--- verilog/dcache_ctrl.sv
// data cache controller: miss, writeback, fill and flush FSM, LL/SC reservation, Wishbone master
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
	parameter int SET_BITS = 3
) (
	input  wire logic                                       CLK,
	input  wire logic                                       nRST,
	input  wire dcache_pkg::cpu_req_t                       req_i,
	input  wire logic                                       halt_i,
	output logic                                            hit_o,
	output dcache_pkg::word_t                               rdata_o,
	output logic                                            flushed_o,
	output dcache_pkg::wb_req_t                             wb_o,
	input  wire dcache_pkg::wb_rsp_t                        wb_i,
	input  wire logic                                       tag_hit_i,
	input  wire logic                                       hit_way_i,
	input  wire logic                                       victim_way_i,
	input  wire logic                                       victim_dirty_i,
	input  wire logic [31-dcache_pkg::OFF_BITS-SET_BITS:0]  victim_tag_i,
	input  wire dcache_pkg::word_t                          rd_word_i,
	output logic [SET_BITS-1:0]                             set_o,
	output logic                                            way_o,
	output logic                                            word_o,
	output logic                                            data_we_o,
	output dcache_pkg::word_t                               data_o,
	output logic                                            fill_o,
	output logic                                            mark_dirty_o,
	output logic                                            clean_o,
	output logic                                            touch_o,
	output logic                                            flush_set_o
);
	import dcache_pkg::*;

	localparam int TAG_BITS = 32 - OFF_BITS - SET_BITS;

	ctrl_state_t state_q, state_d;
	logic miss_way_q, miss_way_d;
	logic [SET_BITS:0] flush_ptr_q, flush_ptr_d; // {set, way}
	word_t rsv_addr_q, rsv_addr_d;
	logic rsv_valid_q, rsv_valid_d;

	logic [SET_BITS-1:0] req_set;
	logic [TAG_BITS-1:0] req_tag;
	logic sc_fail;
	logic flush_last;

	assign req_set = req_i.addr[OFF_BITS +: SET_BITS];
	assign req_tag = req_i.addr[31 -: TAG_BITS];
	assign sc_fail = req_i.wen && req_i.atomic && !(rsv_valid_q && rsv_addr_q == req_i.addr);
	assign flush_last = &flush_ptr_q;
	assign flushed_o = (state_q == HALTED);

	always_comb
	begin
		state_d = state_q;
		miss_way_d = miss_way_q;
		flush_ptr_d = flush_ptr_q;
		rsv_addr_d = rsv_addr_q;
		rsv_valid_d = rsv_valid_q;
		hit_o = 1'b0;
		rdata_o = '0;
		wb_o = '0;
		set_o = req_set;
		way_o = miss_way_q;
		word_o = req_i.addr[BLK_BIT];
		data_we_o = 1'b0;
		data_o = req_i.wdata;
		fill_o = 1'b0;
		mark_dirty_o = 1'b0;
		clean_o = 1'b0;
		touch_o = 1'b0;
		flush_set_o = 1'b0;

		case (state_q)
			IDLE:
			begin
				way_o = tag_hit_i ? hit_way_i : victim_way_i;
				if (halt_i)
				begin
					state_d = FLUSH_SCAN;
					flush_ptr_d = '0;
				end
				else if (sc_fail)
				begin
					hit_o = 1'b1; // answers 0, nothing written
				end
				else if ((req_i.ren || req_i.wen) && tag_hit_i)
				begin
					hit_o = 1'b1;
					touch_o = 1'b1;
					if (req_i.wen)
					begin
						data_we_o = 1'b1;
						mark_dirty_o = 1'b1;
						rdata_o = word_t'(req_i.atomic); // SC success returns 1
						if (req_i.addr == rsv_addr_q)
							rsv_valid_d = 1'b0;
					end
					else
					begin
						rdata_o = rd_word_i;
						if (req_i.atomic)
						begin
							rsv_addr_d = req_i.addr;
							rsv_valid_d = 1'b1;
						end
					end
				end
				else if (req_i.ren || req_i.wen)
				begin
					miss_way_d = victim_way_i;
					state_d = victim_dirty_i ? WB1 : FILL1;
				end
			end
			WB1, WB2:
			begin
				wb_o.cyc = 1'b1;
				wb_o.stb = 1'b1;
				wb_o.we = 1'b1;
				word_o = (state_q == WB2);
				wb_o.adr = {victim_tag_i, req_set, word_o, 2'b00};
				wb_o.dat = rd_word_i;
				if (wb_i.ack)
					state_d = (state_q == WB1) ? WB2 : FILL1;
			end
			FILL1, FILL2:
			begin
				wb_o.cyc = 1'b1;
				wb_o.stb = 1'b1;
				word_o = (state_q == FILL2);
				wb_o.adr = {req_tag, req_set, word_o, 2'b00};
				data_o = wb_i.dat;
				if (wb_i.ack)
				begin
					data_we_o = 1'b1;
					fill_o = (state_q == FILL2); // tag and valid with the last word
					state_d = (state_q == FILL1) ? FILL2 : IDLE;
				end
			end
			FLUSH_SCAN:
			begin
				flush_set_o = 1'b1;
				{set_o, way_o} = flush_ptr_q;
				if (victim_dirty_i)
					state_d = FLUSH1;
				else if (flush_last)
					state_d = HALTED;
				else
					flush_ptr_d = flush_ptr_q + 1'b1;
			end
			FLUSH1, FLUSH2:
			begin
				flush_set_o = 1'b1;
				{set_o, way_o} = flush_ptr_q;
				wb_o.cyc = 1'b1;
				wb_o.stb = 1'b1;
				wb_o.we = 1'b1;
				word_o = (state_q == FLUSH2);
				wb_o.adr = {victim_tag_i, set_o, word_o, 2'b00};
				wb_o.dat = rd_word_i;
				if (wb_i.ack && state_q == FLUSH1)
				begin
					state_d = FLUSH2;
				end
				else if (wb_i.ack)
				begin
					clean_o = 1'b1;
					if (flush_last)
					begin
						state_d = HALTED;
					end
					else
					begin
						flush_ptr_d = flush_ptr_q + 1'b1;
						state_d = FLUSH_SCAN;
					end
				end
			end
			default:
			begin
				state_d = HALTED; // stays until reset
			end
		endcase
	end

	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
		begin
			state_q <= IDLE;
			miss_way_q <= 1'b0;
			flush_ptr_q <= '0;
			rsv_valid_q <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			miss_way_q <= miss_way_d;
			flush_ptr_q <= flush_ptr_d;
			rsv_valid_q <= rsv_valid_d;
		end
	end

	always_ff @(posedge CLK)
	begin
		rsv_addr_q <= rsv_addr_d;
	end

	assert property (@(posedge CLK) disable iff (!nRST) wb_o.stb |-> wb_o.cyc)
		else $error("stb raised without cyc");

	// processor holds its request, so a waiting beat keeps its address
	assert property (@(posedge CLK) disable iff (!nRST)
		wb_o.stb && !wb_i.ack |=> wb_o.stb && $stable(wb_o.adr))
		else $error("wishbone address moved before ack");

endmodule

`default_nettype wire

//--- verilog/dcache_tags.sv
// tag, valid, dirty and LRU arrays with two-way compare and victim choice
`timescale 1ns/1ps
`default_nettype none

module dcache_tags #(
	parameter int SET_BITS = 3
) (
	input  wire logic                                       CLK,
	input  wire logic                                       nRST,
	input  wire logic [SET_BITS-1:0]                        set_i,
	input  wire logic [31-dcache_pkg::OFF_BITS-SET_BITS:0]  tag_i,
	input  wire logic                                       fill_i,
	input  wire logic                                       way_i,
	input  wire logic                                       mark_dirty_i,
	input  wire logic                                       clean_i,
	input  wire logic                                       touch_i,
	output logic                                            hit_o,
	output logic                                            hit_way_o,
	output logic                                            victim_way_o,
	output logic                                            victim_dirty_o,
	output logic [31-dcache_pkg::OFF_BITS-SET_BITS:0]       victim_tag_o
);
	import dcache_pkg::*;

	localparam int SETS = 2 ** SET_BITS;
	localparam int TAG_BITS = 32 - OFF_BITS - SET_BITS;

	logic [1:0][SETS-1:0] valid_q;
	logic [1:0][SETS-1:0] dirty_q;
	logic [SETS-1:0] lru_q; // way to replace next
	logic [TAG_BITS-1:0] tag_q [2][SETS];
	logic [1:0] way_hit;

	assign way_hit[0] = valid_q[0][set_i] && (tag_q[0][set_i] == tag_i);
	assign way_hit[1] = valid_q[1][set_i] && (tag_q[1][set_i] == tag_i);
	assign hit_o = |way_hit;
	assign hit_way_o = way_hit[1];

	// empty way first, else LRU
	assign victim_way_o = !valid_q[0][set_i] ? 1'b0 :
		!valid_q[1][set_i] ? 1'b1 : lru_q[set_i];

	// readback of the way on way_i; on a miss the controller feeds the victim back
	assign victim_dirty_o = valid_q[way_i][set_i] && dirty_q[way_i][set_i];
	assign victim_tag_o = tag_q[way_i][set_i];

	always_ff @(posedge CLK, negedge nRST)
	begin
		if (!nRST)
		begin
			valid_q <= '0;
			dirty_q <= '0;
			lru_q <= '0;
		end
		else
		begin
			if (fill_i)
			begin
				valid_q[way_i][set_i] <= 1'b1;
				dirty_q[way_i][set_i] <= 1'b0;
			end
			if (mark_dirty_i)
				dirty_q[way_i][set_i] <= 1'b1;
			if (clean_i)
				dirty_q[way_i][set_i] <= 1'b0;
			if (touch_i)
				lru_q[set_i] <= ~way_i; // other way ages out
		end
	end

	always_ff @(posedge CLK)
	begin
		if (fill_i)
			tag_q[way_i][set_i] <= tag_i;
	end

	// fills only happen on a miss, so a block never lives in both ways
	assert property (@(posedge CLK) disable iff (!nRST) !(&way_hit))
		else $error("tag hit in both ways");

endmodule

`default_nettype wire

//--- verilog/dcache_data.sv
// two-way data word storage with one write port and one combinational read port
`timescale 1ns/1ps
`default_nettype none

module dcache_data #(
	parameter int SET_BITS = 3
) (
	input  wire logic                 CLK,
	input  wire logic [SET_BITS-1:0]  set_i,
	input  wire logic                 way_i,
	input  wire logic                 word_i,
	input  wire logic                 we_i,
	input  wire dcache_pkg::word_t    wdata_i,
	output dcache_pkg::word_t         rdata_o
);
	import dcache_pkg::*;

	localparam int SETS = 2 ** SET_BITS;

	// [way][set][word in block]
	word_t mem_q [2][SETS][2];

	assign rdata_o = mem_q[way_i][set_i][word_i];

	always_ff @(posedge CLK)
	begin
		if (we_i)
			mem_q[way_i][set_i][word_i] <= wdata_i;
	end

endmodule

`default_nettype wire

//--- verilog/dcache_pkg.sv
// data cache package: address fields, processor and Wishbone structs, controller states
`default_nettype none

package dcache_pkg;

	typedef logic [31:0] word_t;

	// address layout is tag, index, block offset, byte offset
	localparam int BYTE_BITS = 2;
	localparam int BLK_BIT = BYTE_BITS;      // word within block
	localparam int OFF_BITS = BYTE_BITS + 1; // index starts here

	typedef struct packed {
		logic  ren;
		logic  wen;
		logic  atomic; // LL on a load, SC on a store
		word_t addr;
		word_t wdata;
	} cpu_req_t;

	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		word_t adr;
		word_t dat;
	} wb_req_t;

	typedef struct packed {
		logic  ack;
		word_t dat;
	} wb_rsp_t;

	typedef enum logic [3:0] {
		IDLE,
		WB1,
		WB2,
		FILL1,
		FILL2,
		FLUSH_SCAN,
		FLUSH1,
		FLUSH2,
		HALTED
	} ctrl_state_t;

endpackage

`default_nettype wire
